//--- files.f
src/dbg_pkg.sv
src/dbg_fifo.sv
src/dbg_cmd_decoder.sv
src/axil_master.sv
src/axil_ram.sv
src/dbg_top.sv
verification/tb_dbg_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the debug bridge testbench with Verilator and run it.
# The result is read back from sim.log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dbg_top -f files.f -o tb_dbg_top \
    && ./obj_dir/tb_dbg_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
exit 0

//--- verification/tb_dbg_top.sv
/*
 * Debug bridge testbench.
 * Directed tests over the host command port with a RAM scoreboard,
 * an xorshift source, a response monitor and a cycle timeout.
 */
`timescale 1ns/1ps

module tb_dbg_top import dbg_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 4000;      // about twice the worst case.
    localparam logic [31:0] RAM_BYTES      = 32'd1024;  // valid byte range.

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    dbg_cmd_t  cmd;
    logic      resp_valid;
    logic      resp_ready;
    dbg_resp_t resp;

    logic [31:0] sb_mem [RAM_WORDS];   // ram model.
    logic [31:0] rng_state = 32'd64;
    dbg_resp_t   exp_q [$];            // expected, in command order.
    dbg_resp_t   got_q [$];            // seen on the response port.
    int          got_cyc_q [$];
    dbg_resp_t   last_resp;
    int          last_resp_cycle;
    int          prev_resp_cycle;      // transfer cycle of the one before.
    int          last_accept_cycle;
    int          release_cycle;
    int          cycle = 0;
    int          err_count = 0;
    int          test_errs = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    dbg_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;                  // 4 ns period.

    // ********************
    // timeout and monitor
    // ********************
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycle);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // transfer happens on the next rising edge.
    always @(negedge clk) begin
        if (resp_valid && resp_ready) begin
            got_q.push_back(resp);
            got_cyc_q.push_back(cycle);
        end
    end

    // ********************
    // helpers
    // ********************
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_resp(input string name, input dbg_resp_t exp, input dbg_resp_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    // entered and left 1 ns after a rising edge.
    task automatic send_cmd(input dbg_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        forever begin
            @(negedge clk);
            if (cmd_ready) begin
                break;                     // taken on the coming edge.
            end
            @(posedge clk);
            #1;
        end
        last_accept_cycle = cycle;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic bus_op(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic we, input logic [3:0] wstrb);
        dbg_cmd_t  c;
        dbg_resp_t e;
        c          = '0;
        c.req_type = DBG_REQ_BUS;
        c.addr     = addr;
        c.wdata    = wdata;
        c.we       = we;
        c.wstrb    = wstrb;
        e.req_type = DBG_REQ_BUS;
        e.rdata    = 32'h0;            // writes and errors read zero.
        e.err      = (addr >= RAM_BYTES);
        if (!e.err && we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    sb_mem[addr[RAM_IDX_W+1:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!e.err) begin
            e.rdata = sb_mem[addr[RAM_IDX_W+1:2]];
        end
        exp_q.push_back(e);
        send_cmd(c);
    endtask

    task automatic local_op(input dbg_req_e kind, input logic [31:0] param);
        dbg_cmd_t  c;
        dbg_resp_t e;
        c          = '0;
        c.req_type = kind;
        c.param    = param;
        e.req_type = kind;
        e.rdata    = (kind == DBG_REQ_INFO) ? DBG_INFO_ID : 32'h0;
        e.err      = (kind == DBG_REQ_RSVD);
        exp_q.push_back(e);
        send_cmd(c);
    endtask

    // compare every expected response in order.
    task automatic drain();
        dbg_resp_t exp;
        dbg_resp_t act;
        while (exp_q.size() > 0) begin
            while (got_q.size() == 0) begin
                @(posedge clk);
                #1;
            end
            exp             = exp_q.pop_front();
            act             = got_q.pop_front();
            prev_resp_cycle = last_resp_cycle;
            last_resp_cycle = got_cyc_q.pop_front();
            last_resp       = act;
            check_resp("resp", exp, act);
        end
    endtask

    task automatic finish_test(input string name);
        if (got_q.size() != 0) begin
            $display("test %s saw %0d responses nobody asked for", name, got_q.size());
            err_count++;
            got_q.delete();
            got_cyc_q.delete();
        end
        if (err_count == test_errs) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - test_errs);
        end
        test_errs = err_count;
    endtask

    // ********************
    // tests
    // ********************
    task automatic test_info();
        local_op(DBG_REQ_INFO, 32'h0);
        local_op(DBG_REQ_RSVD, 32'h0);
        drain();
        finish_test("info_and_reserved");
    endtask

    task automatic test_write_read();
        bus_op(32'h40, 32'hcafe_f00d, 1'b1, 4'hf);
        bus_op(32'h40, 32'h0, 1'b0, 4'h0);
        drain();
        finish_test("write_read");
    endtask

    task automatic test_strobes();
        bus_op(32'h100, 32'h1122_3344, 1'b1, 4'hf);
        bus_op(32'h100, 32'haaaa_aaaa, 1'b1, 4'h1);   // low byte.
        bus_op(32'h100, 32'h0, 1'b0, 4'h0);
        bus_op(32'h100, 32'hbbbb_bbbb, 1'b1, 4'h6);   // middle bytes.
        bus_op(32'h100, 32'h0, 1'b0, 4'h0);
        bus_op(32'h100, 32'hcccc_cccc, 1'b1, 4'h8);   // top byte.
        bus_op(32'h100, 32'h0, 1'b0, 4'h0);
        drain();
        finish_test("byte_strobes");
    endtask

    task automatic test_random();
        logic [31:0] addrs [16];
        for (int i = 0; i < 16; i++) begin
            addrs[i] = next_rand() & 32'h0000_03fc;   // word aligned, in range.
            bus_op(addrs[i], next_rand(), 1'b1, 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            bus_op(addrs[i], 32'h0, 1'b0, 4'h0);
        end
        drain();
        finish_test("random_back_to_back");
    endtask

    task automatic test_out_of_range();
        logic [31:0] word0;
        word0 = sb_mem[0];
        bus_op(32'h1000, 32'hdead_beef, 1'b1, 4'hf);
        bus_op(32'h1000, 32'h0, 1'b0, 4'h0);
        bus_op(32'h0, 32'h0, 1'b0, 4'h0);             // aliased low word.
        drain();
        check_word("ram word 0", word0, last_resp.rdata);
        finish_test("out_of_range");
    endtask

    task automatic test_move_and_hold();
        int move_accept;
        bus_op(32'h200, 32'h0bad_f00d, 1'b1, 4'hf);
        bus_op(32'h204, 32'h1234_5678, 1'b1, 4'hf);
        bus_op(32'h200, 32'h0, 1'b0, 4'h0);
        local_op(DBG_REQ_MOVE_CLOCK, 32'd20);          // waits for the bus results.
        move_accept = last_accept_cycle;
        drain();
        if (move_accept <= prev_resp_cycle) begin
            $display("clock move was accepted before the earlier bus responses had left");
            err_count++;
        end
        if (last_resp_cycle - move_accept < 20) begin
            $display("clock move answered %0d cycles after acceptance, expected at least 20",
                     last_resp_cycle - move_accept);
            err_count++;
        end
        resp_ready = 1'b0;
        fork
            begin
                repeat (30) @(posedge clk);
                #1;
                release_cycle = cycle;
                resp_ready    = 1'b1;
            end
            for (int i = 0; i < 8; i++) begin
                if (i % 2 == 0) begin
                    bus_op(32'h300 + 32'(4 * i), next_rand(), 1'b1, 4'hf);
                end else begin
                    bus_op(32'h300 + 32'(4 * (i - 1)), 32'h0, 1'b0, 4'h0);
                end
            end
        join
        if (last_accept_cycle <= release_cycle) begin
            $display("eighth command was accepted while responses were held back");
            err_count++;
        end
        drain();
        finish_test("clock_move_and_backpressure");
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        resp_ready = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            sb_mem[i] = 32'h0;             // ram clears on reset.
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        resp_ready = 1'b1;
        test_info();
        test_write_read();
        test_strobes();
        test_random();
        test_out_of_range();
        test_move_and_hold();
        $display("tests passed %0d, tests failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- src/dbg_top.sv
/*
 * Debug access bridge top.
 * Host command port, request and response fifos, AXI4-Lite
 * master and the RAM slave behind it.
 */
`timescale 1ns/1ps

module dbg_top import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  dbg_cmd_t  cmd,
    output logic      resp_valid,
    input  logic      resp_ready,
    output dbg_resp_t resp
);

    // request path.
    logic      req_push;
    logic      req_pop;
    logic      req_full;
    logic      req_empty;
    bus_req_t  req_in;
    bus_req_t  req_head;
    // response path.
    logic      rsp_push;
    logic      rsp_pop;
    logic      rsp_full;
    logic      rsp_empty;
    bus_resp_t rsp_in;
    bus_resp_t rsp_head;
    // axi4-lite bus.
    axil_m2s_t m2s;
    axil_s2m_t s2m;

    dbg_cmd_decoder i_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .req_push   (req_push),
        .req        (req_in),
        .req_full   (req_full),
        .rsp_pop    (rsp_pop),
        .rsp        (rsp_head),
        .rsp_empty  (rsp_empty)
    );

    dbg_fifo #(.T(bus_req_t)) i_req_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (req_push),
        .din   (req_in),
        .pop   (req_pop),
        .dout  (req_head),
        .full  (req_full),
        .empty (req_empty)
    );

    axil_master i_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_empty (req_empty),
        .req       (req_head),
        .req_pop   (req_pop),
        .rsp_full  (rsp_full),
        .rsp_push  (rsp_push),
        .rsp       (rsp_in),
        .m2s       (m2s),
        .s2m       (s2m)
    );

    dbg_fifo #(.T(bus_resp_t)) i_rsp_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rsp_push),
        .din   (rsp_in),
        .pop   (rsp_pop),
        .dout  (rsp_head),
        .full  (rsp_full),
        .empty (rsp_empty)
    );

    axil_ram i_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .m2s   (m2s),
        .s2m   (s2m)
    );

endmodule

//--- src/axil_ram.sv
/*
 * AXI4-Lite RAM slave.
 * Word memory with byte strobes. Addresses past the end answer
 * SLVERR, read back zero and leave the memory alone.
 */
`timescale 1ns/1ps

module axil_ram import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  axil_m2s_t m2s,
    output axil_s2m_t s2m
);

    logic [31:0] mem [RAM_WORDS];   // zero after reset.
    logic        wr_in_range;
    logic        rd_in_range;
    logic        wr_fire;
    logic        rd_fire;

    assign wr_in_range = (m2s.awaddr < 32'(RAM_WORDS * 4));
    assign rd_in_range = (m2s.araddr < 32'(RAM_WORDS * 4));
    assign wr_fire     = m2s.awvalid && s2m.awready && m2s.wvalid && s2m.wready;
    assign rd_fire     = m2s.arvalid && s2m.arready;

    // ********************
    // handshakes
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2m.awready <= 1'b0;
            s2m.wready  <= 1'b0;
            s2m.bvalid  <= 1'b0;
            s2m.arready <= 1'b0;
            s2m.rvalid  <= 1'b0;
        end else begin
            // write: ready one cycle after aw and w are both up.
            if (wr_fire) begin
                s2m.awready <= 1'b0;
                s2m.wready  <= 1'b0;
                s2m.bvalid  <= 1'b1;
                s2m.bresp   <= wr_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
            end else if (m2s.awvalid && m2s.wvalid && !s2m.awready && !s2m.bvalid) begin
                s2m.awready <= 1'b1;
                s2m.wready  <= 1'b1;
            end
            if (s2m.bvalid && m2s.bready) begin
                s2m.bvalid <= 1'b0;
            end
            // read: same pattern on ar and r.
            if (rd_fire) begin
                s2m.arready <= 1'b0;
                s2m.rvalid  <= 1'b1;
                s2m.rresp   <= rd_in_range ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
                s2m.rdata   <= rd_in_range ? mem[m2s.araddr[RAM_IDX_W+1:2]] : '0;
            end else if (m2s.arvalid && !s2m.arready && !s2m.rvalid) begin
                s2m.arready <= 1'b1;
            end
            if (s2m.rvalid && m2s.rready) begin
                s2m.rvalid <= 1'b0;
            end
        end
    end

    // ********************
    // storage
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_fire && wr_in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (m2s.wstrb[b]) begin
                    mem[m2s.awaddr[RAM_IDX_W+1:2]][8*b +: 8] <= m2s.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- src/axil_master.sv
/*
 * AXI4-Lite master.
 * Pops one bus request at a time, runs a single read or write beat
 * and pushes the result into the response fifo.
 */
`timescale 1ns/1ps

module axil_master import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_empty,
    input  bus_req_t  req,
    output logic      req_pop,
    input  logic      rsp_full,
    output logic      rsp_push,
    output bus_resp_t rsp,
    output axil_m2s_t m2s,
    input  axil_s2m_t s2m
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WRITE,    // aw and w presented together.
        ST_WRESP,
        ST_RADDR,
        ST_RDATA
    } state_e;

    state_e state;
    logic   aw_done;
    logic   w_done;

    // start only with room for the answer.
    assign req_pop = (state == ST_IDLE) && !req_empty && !rsp_full;

    assign aw_done = !m2s.awvalid || s2m.awready;   // accepted now or earlier.
    assign w_done  = !m2s.wvalid || s2m.wready;

    // ********************
    // result
    // ********************
    assign rsp_push  = ((state == ST_WRESP) && s2m.bvalid) ||
                       ((state == ST_RDATA) && s2m.rvalid);
    assign rsp.rdata = (state == ST_RDATA) ? s2m.rdata : '0;
    assign rsp.err   = (state == ST_RDATA) ? (s2m.rresp != AXI_RESP_OKAY) :
                                             (s2m.bresp != AXI_RESP_OKAY);

    // ********************
    // fsm
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            m2s.awvalid <= 1'b0;
            m2s.wvalid  <= 1'b0;
            m2s.bready  <= 1'b0;
            m2s.arvalid <= 1'b0;
            m2s.rready  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_pop) begin
                        if (req.we) begin
                            m2s.awvalid <= 1'b1;
                            m2s.awaddr  <= req.addr;
                            m2s.wvalid  <= 1'b1;
                            m2s.wdata   <= req.wdata;
                            m2s.wstrb   <= req.wstrb;
                            state       <= ST_WRITE;
                        end else begin
                            m2s.arvalid <= 1'b1;
                            m2s.araddr  <= req.addr;
                            state       <= ST_RADDR;
                        end
                    end
                end
                ST_WRITE: begin
                    if (s2m.awready) begin
                        m2s.awvalid <= 1'b0;             // each valid drops on its own.
                    end
                    if (s2m.wready) begin
                        m2s.wvalid <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        m2s.bready <= 1'b1;
                        state      <= ST_WRESP;
                    end
                end
                ST_WRESP: begin
                    if (s2m.bvalid) begin
                        m2s.bready <= 1'b0;              // result pushed this cycle.
                        state      <= ST_IDLE;
                    end
                end
                ST_RADDR: begin
                    if (s2m.arready) begin
                        m2s.arvalid <= 1'b0;
                        m2s.rready  <= 1'b1;
                        state       <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (s2m.rvalid) begin
                        m2s.rready <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/dbg_cmd_decoder.sv
/*
 * Debug command decoder.
 * Answers info and clock move commands locally, forwards bus
 * commands to the request fifo and merges bus results back onto
 * the host response port in command order.
 */
`timescale 1ns/1ps

module dbg_cmd_decoder import dbg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  dbg_cmd_t  cmd,
    output logic      resp_valid,
    input  logic      resp_ready,
    output dbg_resp_t resp,
    output logic      req_push,
    output bus_req_t  req,
    input  logic      req_full,
    output logic      rsp_pop,
    input  bus_resp_t rsp,
    input  logic      rsp_empty
);

    logic                  active;        // low in the reset cycle.
    logic [DBG_OUTS_W-1:0] outstanding;   // bus cmds not yet answered.
    logic                  loc_valid;     // local response pending.
    logic [31:0]           move_cnt;      // cycles left for clock move.
    dbg_resp_t             loc_resp;
    logic                  loc_done;
    logic                  is_bus;
    logic                  accept;

    assign is_bus   = (cmd.req_type == DBG_REQ_BUS);
    assign loc_done = loc_valid && (move_cnt == '0);   // local answer ready.
    assign accept   = cmd_valid && cmd_ready;

    // ********************
    // command side
    // ********************
    always_comb begin
        if (!active || loc_valid) begin
            cmd_ready = 1'b0;                            // local answer owns the port.
        end else if (is_bus) begin
            cmd_ready = (outstanding < DBG_OUTS_W'(DBG_MAX_OUTSTANDING)) && !req_full;
        end else begin
            cmd_ready = (outstanding == '0);             // wait for bus results to drain.
        end
    end

    assign req_push    = accept && is_bus;
    assign req.addr    = cmd.addr;
    assign req.wdata   = cmd.wdata;
    assign req.we      = cmd.we;
    assign req.wstrb   = cmd.wstrb;

    // ********************
    // response side
    // ********************
    always_comb begin
        if (loc_done) begin
            resp = loc_resp;
        end else begin
            resp.req_type = DBG_REQ_BUS;                 // head of response fifo.
            resp.rdata    = rsp.rdata;
            resp.err      = rsp.err;
        end
    end

    assign resp_valid = loc_done || !rsp_empty;
    assign rsp_pop    = !loc_done && !rsp_empty && resp_ready;

    // control state.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active      <= 1'b0;
            loc_valid   <= 1'b0;
            move_cnt    <= '0;
            outstanding <= '0;
        end else begin
            active <= 1'b1;
            if (accept && !is_bus) begin
                loc_valid <= 1'b1;
                if (cmd.req_type == DBG_REQ_MOVE_CLOCK && cmd.param != '0) begin
                    move_cnt <= cmd.param - 32'd1;       // zero counts as one.
                end else begin
                    move_cnt <= '0;
                end
            end else if (loc_done && resp_ready) begin
                loc_valid <= 1'b0;                       // local answer taken.
            end else if (loc_valid && move_cnt != '0) begin
                move_cnt <= move_cnt - 32'd1;
            end
            case ({req_push, rsp_pop})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;     // none or both.
            endcase
        end
    end

    // local answer payload.
    always_ff @(posedge clk) begin
        if (accept && !is_bus) begin
            loc_resp.req_type <= cmd.req_type;
            loc_resp.err      <= (cmd.req_type == DBG_REQ_RSVD);
            if (cmd.req_type == DBG_REQ_INFO) begin
                loc_resp.rdata <= DBG_INFO_ID;
            end else begin
                loc_resp.rdata <= '0;                    // move and reserved carry no data.
            end
        end
    end

endmodule

//--- src/dbg_fifo.sv
/*
 * Synchronous fifo.
 * Circular buffer with a type parameter for its payload, used for
 * both the bus request and the bus response queues.
 */
`timescale 1ns/1ps

module dbg_fifo import dbg_pkg::*; #(
    parameter type T     = bus_req_t,
    parameter int  DEPTH = DBG_FIFO_DEPTH
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic full,
    output logic empty
);

    T                           mem [DEPTH];   // payload storage.
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;         // occupancy.
    logic                       do_push;
    logic                       do_pop;

    assign full    = (count == ($clog2(DEPTH+1))'(DEPTH));
    assign empty   = (count == '0);
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // full fifo takes a push with a pop.
    assign dout    = mem[rd_ptr];                 // head item.

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
                    wr_ptr <= '0;                 // wrap.
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage write.
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

//--- src/dbg_pkg.sv
/*
 * Debug bridge package.
 * Host command and response formats, buffered bus request and
 * response items, AXI4-Lite channel bundles and bridge constants.
 */
package dbg_pkg;

    // ********************
    // constants
    // ********************
    localparam logic [31:0] DBG_INFO_ID = 32'hdb61_0100;   // bridge id word.
    localparam int DBG_FIFO_DEPTH      = 4;                // default fifo depth.
    localparam int DBG_MAX_OUTSTANDING = 7;                // both fifos minus one.
    localparam int DBG_OUTS_W          = $clog2(DBG_MAX_OUTSTANDING + 1);
    localparam int RAM_WORDS           = 256;              // 1 KiB of ram.
    localparam int RAM_IDX_W           = $clog2(RAM_WORDS);
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // ********************
    // host side
    // ********************
    typedef enum logic [1:0] {
        DBG_REQ_INFO       = 2'd0,   // id query.
        DBG_REQ_MOVE_CLOCK = 2'd1,   // wait param cycles.
        DBG_REQ_BUS        = 2'd2,   // single word access.
        DBG_REQ_RSVD       = 2'd3    // answered with err.
    } dbg_req_e;

    typedef struct packed {
        dbg_req_e    req_type;
        logic [31:0] param;          // cycle count for clock move.
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;             // 0 read, 1 write.
        logic [3:0]  wstrb;
    } dbg_cmd_t;

    typedef struct packed {
        dbg_req_e    req_type;
        logic [31:0] rdata;
        logic        err;
    } dbg_resp_t;

    // ********************
    // buffered bus items
    // ********************
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
        logic [3:0]  wstrb;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;            // non okay bus response.
    } bus_resp_t;

    // ********************
    // axi4-lite channels
    // ********************
    typedef struct packed {
        logic        awvalid;
        logic [31:0] awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [31:0] araddr;
        logic        rready;
    } axil_m2s_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_s2m_t;

endpackage
